// ==== rtl/cam_capture_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_capture_ctrl (
   input  logic mipi_pclk,
   input  logic rst_n,
   input  logic vsync_i,
   input  logic trigger_capture_frame_i,
   input  logic continuous_capture_frame_i,
   input  logic rgb_gray_i,
   input  logic fifo_wr_i,
   output logic capture_o,
   output logic gray_sel_o,
   output logic vs_fall_o
);

   logic [2:0] trig_sync;
   logic [1:0] cont_sync;
   logic [1:0] gray_sync;
   logic       vsync_q;
   logic       trig_pending;
   logic       trig_rise;
   logic       cont_mode;

   assign trig_rise = trig_sync[1] & ~trig_sync[2];
   assign cont_mode = cont_sync[1];

   assign vs_fall_o  = vsync_q & ~vsync_i;
   assign gray_sel_o = gray_sync[1];

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         trig_sync    <= '0;
         cont_sync    <= '0;
         gray_sync    <= '0;
         vsync_q      <= 1'b0;
         trig_pending <= 1'b0;
         capture_o    <= 1'b0;
      end else begin
         trig_sync <= {trig_sync[1:0], trigger_capture_frame_i};
         cont_sync <= {cont_sync[0], continuous_capture_frame_i};
         gray_sync <= {gray_sync[0], rgb_gray_i};
         vsync_q   <= vsync_i;

         // Request holds until the frame actually starts writing
         if (trig_rise) begin
            trig_pending <= 1'b1;
         end else if (fifo_wr_i) begin
            trig_pending <= 1'b0;
         end

         if ((trig_pending | cont_mode) & vs_fall_o) begin
            capture_o <= 1'b1;
         end else if (capture_o & vs_fall_o & ~cont_mode) begin
            capture_o <= 1'b0;
         end
      end
   end

   // A capture window only ever opens on a frame boundary
   a_capture_on_frame_start : assert property (
      @(posedge mipi_pclk) disable iff (!rst_n)
      $rose(capture_o) |-> $past(vs_fall_o)
   );

endmodule

`default_nettype wire

// ==== rtl/cam_dma_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_dma_fifo (
   input  logic                      mipi_pclk,
   input  logic                      rst_n,
   input  logic                      wr_i,
   input  cam_video_pkg::fifo_word_t wdata_i,
   cam_fifo_rd_if.fifo               rd,
   output logic                      overflow_o,
   output logic                      underflow_o
);

   cam_video_pkg::fifo_word_t mem [cam_dma_pkg::FIFO_DEPTH];

   cam_dma_pkg::fifo_ptr_t wr_ptr;
   cam_dma_pkg::fifo_ptr_t rd_ptr;
   cam_dma_pkg::fifo_ptr_t fill;
   logic                   full;
   logic                   empty;
   logic                   do_wr;
   logic                   do_rd;

   assign fill  = wr_ptr - rd_ptr;
   assign full  = (fill == cam_dma_pkg::fifo_ptr_t'(cam_dma_pkg::FIFO_DEPTH));
   assign empty = (wr_ptr == rd_ptr);

   // A word arriving while full is lost
   assign do_wr = wr_i & ~full;
   assign do_rd = rd.re & ~empty;

   assign overflow_o  = wr_i & full;
   assign underflow_o = rd.re & empty;

   // Fall-through head
   assign rd.rdata  = mem[rd_ptr[cam_dma_pkg::FIFO_AW-1:0]];
   assign rd.rvalid = ~empty;
   assign rd.empty  = empty;

   always_ff @(posedge mipi_pclk) begin
      if (do_wr) begin
         mem[wr_ptr[cam_dma_pkg::FIFO_AW-1:0]] <= wdata_i;
      end
   end

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   a_fill_in_range : assert property (
      @(posedge mipi_pclk) disable iff (!rst_n)
      fill <= cam_dma_pkg::fifo_ptr_t'(cam_dma_pkg::FIFO_DEPTH)
   );

endmodule

`default_nettype wire

// ==== rtl/cam_dma_pkg.sv ====
`default_nettype none

package cam_dma_pkg;

   // Beats per burst, firmware DMA length has to agree
   localparam int DMA_TRANSFER_LENGTH = 16;
   localparam int DMA_COUNT_W         = $clog2(DMA_TRANSFER_LENGTH);

   localparam int FIFO_DEPTH = 32;
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

   // Address plus wrap bit
   typedef logic [FIFO_AW:0] fifo_ptr_t;

   typedef logic [DMA_COUNT_W-1:0] dma_count_t;

   // Frame rate window in clocks, short for simulation
   localparam int FPS_WINDOW = 4000;

   typedef logic [31:0] stat_t;

endpackage

`default_nettype wire

// ==== rtl/cam_dma_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_dma_writer (
   input  logic                     mipi_pclk,
   input  logic                     rst_n,
   input  logic                     init_done_i,
   cam_fifo_rd_if.writer            rd,
   input  logic                     wready_i,
   output logic                     wvalid_o,
   output logic                     wlast_o,
   output logic                     dma_write_o,
   output cam_video_pkg::dma_word_t wdata_o
);

   localparam cam_dma_pkg::dma_count_t LAST_BEAT =
      cam_dma_pkg::dma_count_t'(cam_dma_pkg::DMA_TRANSFER_LENGTH - 1);

   logic [2:0]             init_sync;
   logic                   init_rise;
   cam_dma_pkg::dma_count_t beat_cnt;

   assign init_rise = init_sync[1] & ~init_sync[2];

   assign rd.re    = dma_write_o & wready_i & ~rd.empty;
   assign wvalid_o = rd.re & rd.rvalid;
   assign wlast_o  = wvalid_o & (beat_cnt == LAST_BEAT);

   // Pad each 24-bit pixel to 32 bits
   assign wdata_o = {8'd0, rd.rdata[47:24], 8'd0, rd.rdata[23:0]};

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         init_sync   <= '0;
         dma_write_o <= 1'b0;
         beat_cnt    <= '0;
      end else begin
         init_sync <= {init_sync[1:0], init_done_i};

         // One burst per init done edge
         if (init_rise) begin
            dma_write_o <= 1'b1;
         end else if (wlast_o) begin
            dma_write_o <= 1'b0;
         end

         if (wlast_o) begin
            beat_cnt <= '0;
         end else if (wvalid_o) begin
            beat_cnt <= beat_cnt + 1'b1;
         end
      end
   end

   a_last_ends_burst : assert property (
      @(posedge mipi_pclk) disable iff (!rst_n)
      wlast_o |-> wvalid_o ##1 (beat_cnt == '0)
   );

endmodule

`default_nettype wire

// ==== rtl/cam_fifo_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Read side of the DMA FIFO, head word always on rdata
interface cam_fifo_rd_if;

   logic                     re;
   logic                     rvalid;
   cam_video_pkg::fifo_word_t rdata;
   logic                     empty;

   modport fifo (
      input  re,
      output rvalid,
      output rdata,
      output empty
   );

   modport writer (
      output re,
      input  rvalid,
      input  rdata,
      input  empty
   );

endinterface

`default_nettype wire

// ==== rtl/cam_pixel_pack.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_pixel_pack (
   input  logic                      valid_i,
   input  cam_video_pkg::pix_pair_t  r_i,
   input  cam_video_pkg::pix_pair_t  g_i,
   input  cam_video_pkg::pix_pair_t  b_i,
   input  logic                      capture_i,
   input  logic                      gray_sel_i,
   output logic                      fifo_wr_o,
   output cam_video_pkg::fifo_word_t fifo_wdata_o
);

   cam_video_pkg::pix_t gray0;
   cam_video_pkg::pix_t gray1;

   function automatic cam_video_pkg::pix_t to_gray(
      input cam_video_pkg::pix_t r,
      input cam_video_pkg::pix_t g,
      input cam_video_pkg::pix_t b
   );
      logic [15:0] acc;
      acc = {8'd0, r} * cam_video_pkg::GRAY_WEIGHT_R
          + {8'd0, g} * cam_video_pkg::GRAY_WEIGHT_G
          + {8'd0, b} * cam_video_pkg::GRAY_WEIGHT_B;
      return acc[15:8];
   endfunction

   assign gray0 = to_gray(r_i[7:0], g_i[7:0], b_i[7:0]);
   assign gray1 = to_gray(r_i[15:8], g_i[15:8], b_i[15:8]);

   assign fifo_wr_o = capture_i & valid_i;

   // Pixel 1 in the upper half, BGR order within a pixel
   assign fifo_wdata_o = gray_sel_i ?
      {gray1, gray1, gray1, gray0, gray0, gray0} :
      {b_i[15:8], g_i[15:8], r_i[15:8], b_i[7:0], g_i[7:0], r_i[7:0]};

endmodule

`default_nettype wire

// ==== rtl/cam_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_stats (
   input  logic                mipi_pclk,
   input  logic                rst_n,
   input  logic                vs_fall_i,
   input  logic                fifo_wr_i,
   input  logic                dma_beat_i,
   input  logic                overflow_i,
   input  logic                underflow_i,
   output cam_dma_pkg::stat_t  frames_per_second_o,
   output cam_dma_pkg::stat_t  wcount_o,
   output cam_dma_pkg::stat_t  rcount_o,
   output logic                overflow_flag_o,
   output logic                underflow_flag_o
);

   cam_dma_pkg::stat_t timer_cnt;
   cam_dma_pkg::stat_t frame_cnt;
   logic               window_end;

   assign window_end = (timer_cnt == cam_dma_pkg::stat_t'(cam_dma_pkg::FPS_WINDOW));

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         overflow_flag_o     <= 1'b0;
         underflow_flag_o    <= 1'b0;
         wcount_o            <= '0;
         rcount_o            <= '0;
         timer_cnt           <= '0;
         frame_cnt           <= '0;
         frames_per_second_o <= '0;
      end else begin
         // Sticky until reset
         overflow_flag_o  <= overflow_flag_o | overflow_i;
         underflow_flag_o <= underflow_flag_o | underflow_i;

         if (fifo_wr_i) begin
            wcount_o <= wcount_o + 1'b1;
         end
         if (dma_beat_i) begin
            rcount_o <= rcount_o + 1'b1;
         end

         // Edge on the last window cycle is not counted
         if (window_end) begin
            timer_cnt           <= '0;
            frame_cnt           <= '0;
            frames_per_second_o <= frame_cnt;
         end else begin
            timer_cnt <= timer_cnt + 1'b1;
            if (vs_fall_i) begin
               frame_cnt <= frame_cnt + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/cam_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_top (
   input  logic                     mipi_pclk,
   input  logic                     rst_n,
   input  logic                     sim_cam_vsync_i,
   input  logic                     sim_cam_valid_i,
   input  cam_video_pkg::pix_pair_t sim_cam_r_pix_i,
   input  cam_video_pkg::pix_pair_t sim_cam_g_pix_i,
   input  cam_video_pkg::pix_pair_t sim_cam_b_pix_i,
   input  logic                     trigger_capture_frame_i,
   input  logic                     continuous_capture_frame_i,
   input  logic                     rgb_gray_i,
   input  logic                     cam_dma_init_done_i,
   input  logic                     cam_dma_wready_i,
   output logic                     cam_dma_wvalid_o,
   output logic                     cam_dma_wlast_o,
   output cam_video_pkg::dma_word_t cam_dma_wdata_o,
   output cam_dma_pkg::stat_t       frames_per_second_o,
   output logic                     debug_cam_dma_fifo_overflow_o,
   output logic                     debug_cam_dma_fifo_underflow_o,
   output cam_dma_pkg::stat_t       debug_cam_dma_fifo_rcount_o,
   output cam_dma_pkg::stat_t       debug_cam_dma_fifo_wcount_o,
   output logic [31:0]              debug_cam_dma_status_o
);

   logic                      capture;
   logic                      gray_sel;
   logic                      vs_fall;
   logic                      fifo_wr;
   cam_video_pkg::fifo_word_t fifo_wdata;
   logic                      fifo_overflow;
   logic                      fifo_underflow;
   logic                      dma_write;

   cam_fifo_rd_if fifo_rd ();

   cam_capture_ctrl u_capture_ctrl (
      .mipi_pclk                  (mipi_pclk),
      .rst_n                      (rst_n),
      .vsync_i                    (sim_cam_vsync_i),
      .trigger_capture_frame_i    (trigger_capture_frame_i),
      .continuous_capture_frame_i (continuous_capture_frame_i),
      .rgb_gray_i                 (rgb_gray_i),
      .fifo_wr_i                  (fifo_wr),
      .capture_o                  (capture),
      .gray_sel_o                 (gray_sel),
      .vs_fall_o                  (vs_fall)
   );

   cam_pixel_pack u_pixel_pack (
      .valid_i      (sim_cam_valid_i),
      .r_i          (sim_cam_r_pix_i),
      .g_i          (sim_cam_g_pix_i),
      .b_i          (sim_cam_b_pix_i),
      .capture_i    (capture),
      .gray_sel_i   (gray_sel),
      .fifo_wr_o    (fifo_wr),
      .fifo_wdata_o (fifo_wdata)
   );

   cam_dma_fifo u_dma_fifo (
      .mipi_pclk   (mipi_pclk),
      .rst_n       (rst_n),
      .wr_i        (fifo_wr),
      .wdata_i     (fifo_wdata),
      .rd          (fifo_rd.fifo),
      .overflow_o  (fifo_overflow),
      .underflow_o (fifo_underflow)
   );

   cam_dma_writer u_dma_writer (
      .mipi_pclk   (mipi_pclk),
      .rst_n       (rst_n),
      .init_done_i (cam_dma_init_done_i),
      .rd          (fifo_rd.writer),
      .wready_i    (cam_dma_wready_i),
      .wvalid_o    (cam_dma_wvalid_o),
      .wlast_o     (cam_dma_wlast_o),
      .dma_write_o (dma_write),
      .wdata_o     (cam_dma_wdata_o)
   );

   cam_stats u_stats (
      .mipi_pclk           (mipi_pclk),
      .rst_n               (rst_n),
      .vs_fall_i           (vs_fall),
      .fifo_wr_i           (fifo_wr),
      .dma_beat_i          (cam_dma_wvalid_o),
      .overflow_i          (fifo_overflow),
      .underflow_i         (fifo_underflow),
      .frames_per_second_o (frames_per_second_o),
      .wcount_o            (debug_cam_dma_fifo_wcount_o),
      .rcount_o            (debug_cam_dma_fifo_rcount_o),
      .overflow_flag_o     (debug_cam_dma_fifo_overflow_o),
      .underflow_flag_o    (debug_cam_dma_fifo_underflow_o)
   );

   assign debug_cam_dma_status_o = {29'd0, fifo_rd.empty, dma_write, cam_dma_wready_i};

endmodule

`default_nettype wire

// ==== rtl/cam_video_pkg.sv ====
`default_nettype none

package cam_video_pkg;

   // One 8-bit color sample
   typedef logic [7:0] pix_t;

   // Two samples of one channel, upper byte is the second pixel
   typedef logic [15:0] pix_pair_t;

   // Pixel pair as stored in the DMA FIFO
   // {b1, g1, r1, b0, g0, r0}
   typedef logic [47:0] fifo_word_t;

   // One DMA beat, a zero byte above each 24-bit pixel
   typedef logic [63:0] dma_word_t;

   // Luma weights in 1/256 steps, they sum to 256
   localparam pix_t GRAY_WEIGHT_R = 8'd77;
   localparam pix_t GRAY_WEIGHT_G = 8'd150;
   localparam pix_t GRAY_WEIGHT_B = 8'd29;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cam_top -f verilog.f

out=$(./obj_dir/Vtb_cam_top)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
   exit 0
fi
exit 1

// ==== testbench/tb_cam_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cam_top;

   localparam int BURST         = cam_dma_pkg::DMA_TRANSFER_LENGTH;
   localparam int FPS_PERIOD    = cam_dma_pkg::FPS_WINDOW + 1;
   localparam int BURST_TIMEOUT = 2000;
   localparam int PAIRS_PER_LINE = 8;

   logic                     mipi_pclk;
   logic                     rst_n;
   logic                     sim_cam_vsync_i;
   logic                     sim_cam_valid_i;
   cam_video_pkg::pix_pair_t sim_cam_r_pix_i;
   cam_video_pkg::pix_pair_t sim_cam_g_pix_i;
   cam_video_pkg::pix_pair_t sim_cam_b_pix_i;
   logic                     trigger_capture_frame_i;
   logic                     continuous_capture_frame_i;
   logic                     rgb_gray_i;
   logic                     cam_dma_init_done_i;
   logic                     cam_dma_wready_i;
   logic                     cam_dma_wvalid_o;
   logic                     cam_dma_wlast_o;
   cam_video_pkg::dma_word_t cam_dma_wdata_o;
   cam_dma_pkg::stat_t       frames_per_second_o;
   logic                     debug_cam_dma_fifo_overflow_o;
   logic                     debug_cam_dma_fifo_underflow_o;
   cam_dma_pkg::stat_t       debug_cam_dma_fifo_rcount_o;
   cam_dma_pkg::stat_t       debug_cam_dma_fifo_wcount_o;
   logic [31:0]              debug_cam_dma_status_o;

   logic                     wready_random;
   logic                     wready_level;
   logic [31:0]              rnd_ready;
   integer                   seed;
   cam_video_pkg::dma_word_t exp_q [$];
   int                       errors;
   int                       timeouts;
   int                       beats_seen;
   int                       bursts_done;
   int                       exp_wcount;
   int                       vs_falls;
   int                       pclk_cycles;

   cam_top u_dut (.*);

   always #4 mipi_pclk = ~mipi_pclk;

   // Random back-pressure or a fixed level
   always @(negedge mipi_pclk) begin
      rnd_ready = $random(seed);
      cam_dma_wready_i = wready_random ? rnd_ready[0] : wready_level;
   end

   // Index of the next clock edge since reset release
   always @(posedge mipi_pclk) begin
      if (rst_n) begin
         pclk_cycles <= pclk_cycles + 1;
      end
   end

   // Gray is (77 r + 150 g + 29 b) / 256
   // Each pixel padded to 32 bits
   function automatic cam_video_pkg::dma_word_t expect_word(
      input cam_video_pkg::pix_pair_t r,
      input cam_video_pkg::pix_pair_t g,
      input cam_video_pkg::pix_pair_t b,
      input logic                     gray
   );
      int unsigned y0;
      int unsigned y1;
      y0 = (77 * r[7:0] + 150 * g[7:0] + 29 * b[7:0]) >> 8;
      y1 = (77 * r[15:8] + 150 * g[15:8] + 29 * b[15:8]) >> 8;
      if (gray) begin
         return {8'h00, y1[7:0], y1[7:0], y1[7:0], 8'h00, y0[7:0], y0[7:0], y0[7:0]};
      end
      return {8'h00, b[15:8], g[15:8], r[15:8], 8'h00, b[7:0], g[7:0], r[7:0]};
   endfunction

   task automatic check_word(input string name, input cam_video_pkg::dma_word_t got,
                             input cam_video_pkg::dma_word_t exp);
      if (got !== exp) begin
         $display("error %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_stat(input string name, input cam_dma_pkg::stat_t got,
                             input cam_dma_pkg::stat_t exp);
      if (got !== exp) begin
         $display("error %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("error %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Every accepted beat against the head of the expected queue
   always @(posedge mipi_pclk) begin
      if (rst_n && cam_dma_wvalid_o && cam_dma_wready_i) begin
         if (exp_q.size() == 0) begin
            $display("DMA beat %0d arrived while no word was expected", beats_seen);
            errors++;
         end else begin
            check_word("cam_dma_wdata_o", cam_dma_wdata_o, exp_q.pop_front());
         end
         check_bit("cam_dma_wlast_o", cam_dma_wlast_o, (beats_seen % BURST) == BURST - 1);
         if (cam_dma_wlast_o) begin
            bursts_done++;
         end
         beats_seen++;
      end
   end

   task automatic pulse_trigger();
      trigger_capture_frame_i = 1'b1;
      repeat (4) @(negedge mipi_pclk);
      trigger_capture_frame_i = 1'b0;
      repeat (4) @(negedge mipi_pclk);
   endtask

   // Vsync high over the active lines and low between frames
   task automatic send_frame(input int lines, input logic captured, input logic gray,
                             input int max_kept);
      int          ln;
      int          px;
      int          kept;
      logic [31:0] rnd;
      kept = 0;
      @(negedge mipi_pclk);
      sim_cam_vsync_i = 1'b1;
      repeat (4) @(negedge mipi_pclk);
      for (ln = 0; ln < lines; ln++) begin
         for (px = 0; px < PAIRS_PER_LINE; px++) begin
            rnd = $random(seed);
            sim_cam_r_pix_i = rnd[15:0];
            sim_cam_g_pix_i = rnd[31:16];
            rnd = $random(seed);
            sim_cam_b_pix_i = rnd[15:0];
            sim_cam_valid_i = 1'b1;
            if (captured) begin
               exp_wcount++;
               // Words beyond a full FIFO are dropped
               if (kept < max_kept) begin
                  exp_q.push_back(expect_word(sim_cam_r_pix_i, sim_cam_g_pix_i,
                                              sim_cam_b_pix_i, gray));
                  kept++;
               end
            end
            @(negedge mipi_pclk);
         end
         sim_cam_valid_i = 1'b0;
         repeat (4) @(negedge mipi_pclk);
      end
      sim_cam_vsync_i = 1'b0;
      vs_falls++;
      repeat (10) @(negedge mipi_pclk);
   endtask

   task automatic drain_bursts(input int count);
      int n;
      int target;
      int waited;
      for (n = 0; n < count; n++) begin
         target = bursts_done + 1;
         cam_dma_init_done_i = 1'b1;
         repeat (2) @(negedge mipi_pclk);
         cam_dma_init_done_i = 1'b0;
         waited = 0;
         while (bursts_done < target && waited < BURST_TIMEOUT) begin
            @(negedge mipi_pclk);
            waited++;
         end
         if (bursts_done < target) begin
            $display("timeout waiting for the end of DMA burst %0d", n);
            timeouts++;
         end
         repeat (2) @(negedge mipi_pclk);
      end
   endtask

   task automatic check_counts();
      repeat (4) @(negedge mipi_pclk);
      if (exp_q.size() != 0) begin
         $display("%0d expected DMA words never appeared", exp_q.size());
         errors++;
         exp_q.delete();
      end
      check_stat("debug_cam_dma_fifo_wcount_o", debug_cam_dma_fifo_wcount_o,
                 cam_dma_pkg::stat_t'(exp_wcount));
      check_stat("debug_cam_dma_fifo_rcount_o", debug_cam_dma_fifo_rcount_o,
                 cam_dma_pkg::stat_t'(beats_seen));
   endtask

   task automatic wait_window_offset(input int offset);
      int waited;
      waited = 0;
      while ((pclk_cycles % FPS_PERIOD) != offset && waited < 2 * FPS_PERIOD) begin
         @(negedge mipi_pclk);
         waited++;
      end
      if ((pclk_cycles % FPS_PERIOD) != offset) begin
         $display("timeout waiting for offset %0d of the frame rate window", offset);
         timeouts++;
      end
   endtask

   initial begin
      int falls_before;
      int fps_expect;
      seed                       = 32'h0a9d_d4de;
      mipi_pclk                  = 1'b0;
      rst_n                      = 1'b0;
      sim_cam_vsync_i            = 1'b0;
      sim_cam_valid_i            = 1'b0;
      sim_cam_r_pix_i            = '0;
      sim_cam_g_pix_i            = '0;
      sim_cam_b_pix_i            = '0;
      trigger_capture_frame_i    = 1'b0;
      continuous_capture_frame_i = 1'b0;
      rgb_gray_i                 = 1'b0;
      cam_dma_init_done_i        = 1'b0;
      cam_dma_wready_i           = 1'b1;
      wready_random              = 1'b0;
      wready_level               = 1'b1;
      repeat (16) @(negedge mipi_pclk);
      rst_n = 1'b1;
      repeat (4) @(negedge mipi_pclk);

      // Nothing requested yet
      send_frame(2, 1'b0, 1'b0, 0);
      send_frame(2, 1'b0, 1'b0, 0);
      check_counts();
      check_stat("debug_cam_dma_status_o", debug_cam_dma_status_o, 32'h0000_0005);

      // Single trigger captures only the frame after the next vsync fall
      wready_random = 1'b1;
      pulse_trigger();
      send_frame(1, 1'b0, 1'b0, 0);
      send_frame(4, 1'b1, 1'b0, 1000);
      send_frame(1, 1'b0, 1'b0, 0);
      drain_bursts(2);
      check_counts();

      rgb_gray_i = 1'b1;
      pulse_trigger();
      send_frame(1, 1'b0, 1'b1, 0);
      send_frame(4, 1'b1, 1'b1, 1000);
      drain_bursts(2);
      check_counts();
      rgb_gray_i = 1'b0;

      // Continuous mode switched off ahead of the last captured frame
      continuous_capture_frame_i = 1'b1;
      send_frame(1, 1'b0, 1'b0, 0);
      send_frame(4, 1'b1, 1'b0, 1000);
      drain_bursts(2);
      continuous_capture_frame_i = 1'b0;
      send_frame(4, 1'b1, 1'b0, 1000);
      drain_bursts(2);
      send_frame(1, 1'b0, 1'b0, 0);
      check_counts();

      // Armed writer held off by wready through a frame larger than the FIFO
      wready_random       = 1'b0;
      wready_level        = 1'b0;
      cam_dma_init_done_i = 1'b1;
      repeat (2) @(negedge mipi_pclk);
      cam_dma_init_done_i = 1'b0;
      pulse_trigger();
      send_frame(1, 1'b0, 1'b0, 0);
      send_frame(6, 1'b1, 1'b0, cam_dma_pkg::FIFO_DEPTH);
      check_bit("debug_cam_dma_fifo_overflow_o", debug_cam_dma_fifo_overflow_o, 1'b1);
      check_stat("debug_cam_dma_status_o", debug_cam_dma_status_o, 32'h0000_0002);
      wready_random = 1'b1;
      drain_bursts(2);
      check_counts();
      check_bit("debug_cam_dma_fifo_overflow_o", debug_cam_dma_fifo_overflow_o, 1'b1);
      check_bit("debug_cam_dma_fifo_underflow_o", debug_cam_dma_fifo_underflow_o, 1'b0);

      // Frame rate over one full window
      wait_window_offset(0);
      wait_window_offset(200);
      falls_before = vs_falls;
      repeat (5) send_frame(1, 1'b0, 1'b0, 0);
      fps_expect = vs_falls - falls_before;
      wait_window_offset(100);
      check_stat("frames_per_second_o", frames_per_second_o,
                 cam_dma_pkg::stat_t'(fps_expect));

      $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/cam_video_pkg.sv
rtl/cam_dma_pkg.sv
rtl/cam_fifo_rd_if.sv
rtl/cam_capture_ctrl.sv
rtl/cam_pixel_pack.sv
rtl/cam_dma_fifo.sv
rtl/cam_dma_writer.sv
rtl/cam_stats.sv
rtl/cam_top.sv
testbench/tb_cam_top.sv
